//--- logic/cnn_pkg.sv
package cnn_pkg;

    // ============================================================
    // image, kernel and layer sizes
    // ============================================================
    localparam int IMG_W  = 8;
    localparam int IMG_H  = 8;
    localparam int K_SIZE = 3;
    localparam int KERN_N = K_SIZE * K_SIZE;
    localparam int N_CH   = 2;

    localparam int CONV_W = IMG_W - K_SIZE + 1;
    localparam int CONV_H = IMG_H - K_SIZE + 1;
    localparam int POOL_W = CONV_W / 2;
    localparam int POOL_H = CONV_H / 2;
    localparam int POOL_N = POOL_W * POOL_H;

    // counter widths
    localparam int IMG_IDX_W  = $clog2(IMG_W);
    localparam int CONV_IDX_W = $clog2(CONV_W);
    localparam int FEAT_CNT_W = $clog2(POOL_N);

    // 9 weights per channel, then one bias per channel
    localparam int CFG_N_REGS = 20;

    localparam int ACT_MAX = 65535;

    // ============================================================
    // data types
    // ============================================================
    typedef logic        [7:0]  pixel_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic signed [15:0] bias_t;
    typedef logic signed [20:0] acc_t;
    typedef logic        [15:0] act_t;
    typedef logic        [19:0] score_t;
    typedef logic        [4:0]  cfg_addr_t;
    typedef logic               class_t;

    // w[0] is the top-left tap, row-major
    typedef struct packed {
        weight_t [KERN_N-1:0] w;
        bias_t                b;
    } kernel_t;

    // p[KERN_N-1] is the newest pixel
    typedef struct packed {
        pixel_t [KERN_N-1:0] p;
    } window_t;

    typedef struct packed {
        act_t [N_CH-1:0] ch;
    } act_pair_t;

endpackage

//--- logic/cnn_weight_regs.sv
`timescale 1ns/1ps

module cnn_weight_regs
    import cnn_pkg::*;
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                i_cfg_we,
    input  cfg_addr_t           i_cfg_addr,
    input  logic [15:0]         i_cfg_data,
    output kernel_t [N_CH-1:0]  o_kernel
);

    kernel_t [N_CH-1:0] r_kernel;
    logic               cfg_hit;

    // addresses 20..31 fall outside the register map
    assign cfg_hit = i_cfg_we && (i_cfg_addr < cfg_addr_t'(CFG_N_REGS));

    // ============================================================
    // address decode
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_kernel <= '0;
        end else if (cfg_hit) begin
            for (int c = 0; c < N_CH; c++) begin
                // weights, low byte only
                for (int k = 0; k < KERN_N; k++) begin
                    if (i_cfg_addr == cfg_addr_t'(c * KERN_N + k)) begin
                        r_kernel[c].w[k] <= weight_t'(i_cfg_data[7:0]);
                    end
                end
                // biases after all weights
                if (i_cfg_addr == cfg_addr_t'(N_CH * KERN_N + c)) begin
                    r_kernel[c].b <= bias_t'(i_cfg_data);
                end
            end
        end
    end

    assign o_kernel = r_kernel;

endmodule

//--- logic/conv_window.sv
`timescale 1ns/1ps

module conv_window
    import cnn_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    i_pix_valid,
    input  pixel_t  i_pix,
    output logic    o_win_valid,
    output window_t o_window
);

    logic [IMG_IDX_W-1:0] col;
    logic [IMG_IDX_W-1:0] row;

    // one and two rows above the current pixel
    pixel_t  line_1 [IMG_W];
    pixel_t  line_2 [IMG_W];

    window_t r_window;
    logic    r_win_valid;
    logic    full_window;

    // no padding, window needs K_SIZE-1 rows and columns behind it
    assign full_window = (row >= IMG_IDX_W'(K_SIZE - 1)) &&
                         (col >= IMG_IDX_W'(K_SIZE - 1));

    // ============================================================
    // raster position
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col <= '0;
            row <= '0;
        end else if (i_pix_valid) begin
            if (col == IMG_IDX_W'(IMG_W - 1)) begin
                col <= '0;
                if (row == IMG_IDX_W'(IMG_H - 1)) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_win_valid <= 1'b0;
        end else begin
            r_win_valid <= i_pix_valid && full_window;
        end
    end

    // ============================================================
    // line buffers and 3x3 window
    // ============================================================
    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            line_2[col] <= line_1[col];
            line_1[col] <= i_pix;
            // shift window left by one column
            for (int r = 0; r < K_SIZE; r++) begin
                for (int c = 0; c < K_SIZE - 1; c++) begin
                    r_window.p[r * K_SIZE + c] <= r_window.p[r * K_SIZE + c + 1];
                end
            end
            // newest column on the right
            r_window.p[K_SIZE - 1]     <= line_2[col];
            r_window.p[2 * K_SIZE - 1] <= line_1[col];
            r_window.p[KERN_N - 1]     <= i_pix;
        end
    end

    assign o_win_valid = r_win_valid;
    assign o_window    = r_window;

endmodule

//--- logic/conv_mac.sv
`timescale 1ns/1ps

module conv_mac
    import cnn_pkg::*;
(
    input  logic               clk,
    input  logic               reset_n,
    input  logic               i_win_valid,
    input  window_t            i_window,
    input  kernel_t [N_CH-1:0] i_kernel,
    output logic               o_act_valid,
    output act_pair_t          o_act
);

    acc_t      acc [N_CH];
    act_pair_t act_next;
    act_pair_t r_act;
    logic      r_act_valid;

    // ============================================================
    // multiply-accumulate per channel
    // ============================================================
    always_comb begin
        for (int c = 0; c < N_CH; c++) begin
            acc[c] = $signed(i_kernel[c].b);
            for (int k = 0; k < KERN_N; k++) begin
                // pixel widened with a zero msb so it stays non-negative
                acc[c] = acc[c] + $signed({1'b0, i_window.p[k]}) *
                                  $signed(i_kernel[c].w[k]);
            end
        end
    end

    // relu and saturation to act_t
    always_comb begin
        for (int c = 0; c < N_CH; c++) begin
            if (acc[c] < 0) begin
                act_next.ch[c] = '0;
            end else if (acc[c] > ACT_MAX) begin
                act_next.ch[c] = act_t'(ACT_MAX);
            end else begin
                act_next.ch[c] = acc[c][15:0];
            end
        end
    end

    // ============================================================
    // output register
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_act_valid <= 1'b0;
        end else begin
            r_act_valid <= i_win_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_win_valid) begin
            r_act <= act_next;
        end
    end

    assign o_act_valid = r_act_valid;
    assign o_act       = r_act;

endmodule

//--- logic/max_pool.sv
`timescale 1ns/1ps

module max_pool
    import cnn_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      i_act_valid,
    input  act_pair_t i_act,
    output logic      o_feat_valid,
    output act_pair_t o_feat
);

    logic [CONV_IDX_W-1:0] col;
    logic [CONV_IDX_W-1:0] row;

    act_pair_t h_first;                 // left value of the horizontal pair
    act_t      row_buf [N_CH][POOL_W];  // pair maxima from the even row
    act_pair_t pair_max;
    act_pair_t r_feat;
    logic      r_feat_valid;

    function automatic act_t act_max(input act_t a, input act_t b);
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        for (int c = 0; c < N_CH; c++) begin
            pair_max.ch[c] = act_max(h_first.ch[c], i_act.ch[c]);
        end
    end

    // ============================================================
    // conv position
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col          <= '0;
            row          <= '0;
            r_feat_valid <= 1'b0;
        end else begin
            r_feat_valid <= i_act_valid && col[0] && row[0];
            if (i_act_valid) begin
                if (col == CONV_IDX_W'(CONV_W - 1)) begin
                    col <= '0;
                    row <= (row == CONV_IDX_W'(CONV_H - 1)) ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // pair and block maxima
    always_ff @(posedge clk) begin
        if (i_act_valid) begin
            if (!col[0]) begin
                h_first <= i_act;
            end else begin
                for (int c = 0; c < N_CH; c++) begin
                    if (!row[0]) begin
                        row_buf[c][col[CONV_IDX_W-1:1]] <= pair_max.ch[c];
                    end else begin
                        r_feat.ch[c] <= act_max(row_buf[c][col[CONV_IDX_W-1:1]],
                                                pair_max.ch[c]);
                    end
                end
            end
        end
    end

    assign o_feat_valid = r_feat_valid;
    assign o_feat       = r_feat;

endmodule

//--- logic/class_scorer.sv
`timescale 1ns/1ps

module class_scorer
    import cnn_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      i_feat_valid,
    input  act_pair_t i_feat,
    output logic      o_done,
    output class_t    o_class
);

    score_t                sum   [N_CH];
    score_t                total [N_CH];
    logic [FEAT_CNT_W-1:0] feat_cnt;
    logic                  last_feat;
    logic                  r_done;
    class_t                r_class;

    // running sum including the current feature
    always_comb begin
        for (int c = 0; c < N_CH; c++) begin
            total[c] = sum[c] + i_feat.ch[c];
        end
    end

    assign last_feat = (feat_cnt == FEAT_CNT_W'(POOL_N - 1));

    // ============================================================
    // accumulate, decide on the ninth feature
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum      <= '{default: '0};
            feat_cnt <= '0;
            r_done   <= 1'b0;
            r_class  <= 1'b0;
        end else begin
            r_done <= i_feat_valid && last_feat;
            if (i_feat_valid) begin
                if (last_feat) begin
                    // channel 1 wins only when strictly larger
                    r_class  <= class_t'(total[1] > total[0]);
                    sum      <= '{default: '0};
                    feat_cnt <= '0;
                end else begin
                    sum      <= total;
                    feat_cnt <= feat_cnt + 1'b1;
                end
            end
        end
    end

    assign o_done  = r_done;
    assign o_class = r_class;

endmodule

//--- logic/cnn_top.sv
`timescale 1ns/1ps

module cnn_top
    import cnn_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        i_pix_valid,
    input  pixel_t      i_pix,
    input  logic        i_cfg_we,
    input  cfg_addr_t   i_cfg_addr,
    input  logic [15:0] i_cfg_data,
    output logic        o_feat_valid,
    output act_pair_t   o_feat,
    output logic        o_done,
    output class_t      o_class
);

    kernel_t [N_CH-1:0] kernel;
    logic               win_valid;
    window_t            window;
    logic               act_valid;
    act_pair_t          act;

    // ============================================================
    // pipeline: window -> mac -> pool -> scorer
    // ============================================================
    cnn_weight_regs u_weight_regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_cfg_we   (i_cfg_we),
        .i_cfg_addr (i_cfg_addr),
        .i_cfg_data (i_cfg_data),
        .o_kernel   (kernel)
    );

    conv_window u_conv_window (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_win_valid (win_valid),
        .o_window    (window)
    );

    conv_mac u_conv_mac (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_win_valid (win_valid),
        .i_window    (window),
        .i_kernel    (kernel),
        .o_act_valid (act_valid),
        .o_act       (act)
    );

    max_pool u_max_pool (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_act_valid  (act_valid),
        .i_act        (act),
        .o_feat_valid (o_feat_valid),
        .o_feat       (o_feat)
    );

    class_scorer u_class_scorer (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_feat_valid (o_feat_valid),
        .i_feat       (o_feat),
        .o_done       (o_done),
        .o_class      (o_class)
    );

endmodule

//--- tb/cnn_ref_model.svh
`ifndef CNN_REF_MODEL_SVH
`define CNN_REF_MODEL_SVH

// ============================================================
// copies of the configuration and the current frame
// ============================================================
logic [15:0] cfg_copy [CFG_N_REGS];
pixel_t      pix_copy [IMG_W * IMG_H];

function automatic void model_reset();
    for (int a = 0; a < CFG_N_REGS; a++) begin
        cfg_copy[a] = '0;
    end
endfunction

// writes outside the register map are dropped
function automatic void model_cfg_write(input cfg_addr_t addr, input logic [15:0] data);
    if (int'(addr) < CFG_N_REGS) begin
        cfg_copy[addr] = data;
    end
endfunction

// ============================================================
// convolution, pooling and class decision
// ============================================================
function automatic int model_conv(input int ch, input int r, input int c);
    weight_t w;
    bias_t   b;
    int      acc;
    b   = cfg_copy[N_CH * KERN_N + ch];
    acc = int'(b);
    for (int kr = 0; kr < K_SIZE; kr++) begin
        for (int kc = 0; kc < K_SIZE; kc++) begin
            // only the low byte of a weight register counts
            w   = cfg_copy[ch * KERN_N + kr * K_SIZE + kc][7:0];
            acc = acc + int'(pix_copy[(r + kr) * IMG_W + c + kc]) * int'(w);
        end
    end
    if (acc < 0) begin
        return 0;
    end
    if (acc > ACT_MAX) begin
        return ACT_MAX;
    end
    return acc;
endfunction

function automatic int model_pool(input int ch, input int pr, input int pc);
    int m;
    int v;
    m = 0;
    for (int dr = 0; dr < 2; dr++) begin
        for (int dc = 0; dc < 2; dc++) begin
            v = model_conv(ch, 2 * pr + dr, 2 * pc + dc);
            if (v > m) begin
                m = v;
            end
        end
    end
    return m;
endfunction

// tie goes to class 0
function automatic class_t model_class();
    int sum [N_CH];
    for (int c = 0; c < N_CH; c++) begin
        sum[c] = 0;
        for (int pr = 0; pr < POOL_H; pr++) begin
            for (int pc = 0; pc < POOL_W; pc++) begin
                sum[c] = sum[c] + model_pool(c, pr, pc);
            end
        end
    end
    return class_t'(sum[1] > sum[0]);
endfunction

`endif

//--- tb/tb_cnn_top.sv
`timescale 1ns/1ps

module tb_cnn_top
    import cnn_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int FRAME_PIX  = IMG_W * IMG_H;
    localparam int N_FRAMES   = 11;
    localparam int MAX_GAP    = 4;
    localparam int DONE_WAIT  = 20;
    localparam int RUN_CYCLES = N_FRAMES * (FRAME_PIX * (1 + MAX_GAP) + CFG_N_REGS + 20) + 8;

    logic        clk;
    logic        reset_n;
    logic        i_pix_valid;
    pixel_t      i_pix;
    logic        i_cfg_we;
    cfg_addr_t   i_cfg_addr;
    logic [15:0] i_cfg_data;
    logic        o_feat_valid;
    act_pair_t   o_feat;
    logic        o_done;
    class_t      o_class;

    integer seed;
    int     cycle;
    int     errors;
    int     errors_at_start;
    int     tests_run;
    int     tests_failed;
    int     frames_sent;
    int     done_count;

    pixel_t    saved_img [3][FRAME_PIX];
    act_pair_t exp_feat [$];
    act_pair_t obs_feat [$];
    class_t    exp_class [$];
    class_t    obs_class [$];
    int        exp_done_cycle [$];
    int        obs_done_cycle [$];

    `include "cnn_ref_model.svh"

    cnn_top DUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_pix_valid  (i_pix_valid),
        .i_pix        (i_pix),
        .i_cfg_we     (i_cfg_we),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_data   (i_cfg_data),
        .o_feat_valid (o_feat_valid),
        .o_feat       (o_feat),
        .o_done       (o_done),
        .o_class      (o_class)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle = cycle + 1;
    end

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (reset_n) begin
            if (o_feat_valid) begin
                obs_feat.push_back(o_feat);
            end
            if (o_done) begin
                obs_class.push_back(o_class);
                obs_done_cycle.push_back(cycle);
                done_count++;
            end
        end
    end

    // ============================================================
    // stimulus helpers
    // ============================================================
    function automatic int rand_range(input int lo, input int span);
        int r;
        r = int'($unsigned($random(seed)) % span);
        return lo + r;
    endfunction

    task automatic cfg_write(input cfg_addr_t addr, input logic [15:0] data);
        i_cfg_we   = 1'b1;
        i_cfg_addr = addr;
        i_cfg_data = data;
        model_cfg_write(addr, data);
        @(negedge clk);
        i_cfg_we = 1'b0;
    endtask

    // upper byte of a weight write is junk on purpose
    task automatic random_config(input int w_lo, input int w_span, input int b_lo,
                                 input int b_span);
        for (int a = 0; a < N_CH * KERN_N; a++) begin
            cfg_write(cfg_addr_t'(a), {8'($random(seed)), 8'(rand_range(w_lo, w_span))});
        end
        for (int c = 0; c < N_CH; c++) begin
            cfg_write(cfg_addr_t'(N_CH * KERN_N + c), 16'(rand_range(b_lo, b_span)));
        end
    endtask

    task automatic random_image(input int lo, input int span);
        for (int i = 0; i < FRAME_PIX; i++) begin
            pix_copy[i] = pixel_t'(rand_range(lo, span));
        end
    endtask

    task automatic expect_frame();
        act_pair_t f;
        for (int pr = 0; pr < POOL_H; pr++) begin
            for (int pc = 0; pc < POOL_W; pc++) begin
                for (int c = 0; c < N_CH; c++) begin
                    f.ch[c] = act_t'(model_pool(c, pr, pc));
                end
                exp_feat.push_back(f);
            end
        end
        exp_class.push_back(model_class());
    endtask

    task automatic stream_frame(input int max_gap);
        int gap;
        expect_frame();
        for (int i = 0; i < FRAME_PIX; i++) begin
            i_pix_valid = 1'b1;
            i_pix       = pix_copy[i];
            if (i == FRAME_PIX - 1) begin
                exp_done_cycle.push_back(cycle + 4);
            end
            @(negedge clk);
            i_pix_valid = 1'b0;
            if (max_gap > 0) begin
                gap = rand_range(1, max_gap);
                repeat (gap) @(negedge clk);
            end
        end
        frames_sent++;
    endtask

    // ============================================================
    // checking
    // ============================================================
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] observed);
        if (expected !== observed) begin
            $display("[ERROR] %0t ns %s expected %0d observed %0d",
                     $time, name, expected, observed);
            errors++;
        end
    endtask

    task automatic check_frame();
        int        waited;
        act_pair_t exp_f;
        act_pair_t obs_f;
        waited = 0;
        while (obs_class.size() < exp_class.size() && waited < DONE_WAIT) begin
            @(negedge clk);
            waited++;
        end
        while (exp_feat.size() > 0) begin
            exp_f = exp_feat.pop_front();
            if (obs_feat.size() == 0) begin
                $display("missing feature, the DUT gave fewer than %0d", POOL_N);
                errors++;
            end else begin
                obs_f = obs_feat.pop_front();
                for (int c = 0; c < N_CH; c++) begin
                    check_value($sformatf("o_feat.ch[%0d]", c), exp_f.ch[c], obs_f.ch[c]);
                end
            end
        end
        if (obs_feat.size() > 0) begin
            $display("the DUT gave %0d features more than expected", obs_feat.size());
            errors++;
            obs_feat.delete();
        end
        while (exp_class.size() > 0) begin
            if (obs_class.size() == 0) begin
                $display("o_done did not pulse within %0d cycles after the frame", DONE_WAIT);
                errors++;
                void'(exp_class.pop_front());
                void'(exp_done_cycle.pop_front());
            end else begin
                check_value("o_class", exp_class.pop_front(), obs_class.pop_front());
                check_value("o_done cycle", exp_done_cycle.pop_front(),
                            obs_done_cycle.pop_front());
            end
        end
    endtask

    task automatic end_test(input int num, input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name,
                     errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        clk             = 1'b0;
        reset_n         = 1'b0;
        i_pix_valid     = 1'b0;
        i_pix           = '0;
        i_cfg_we        = 1'b0;
        i_cfg_addr      = '0;
        i_cfg_data      = '0;
        seed            = 32'h9478;
        cycle           = 0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        frames_sent     = 0;
        done_count      = 0;
        model_reset();
        repeat (8) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        // registers still hold their reset zeros
        random_image(0, 256);
        stream_frame(0);
        check_frame();
        end_test(1, "zero weights after reset");

        random_config(0, 8, 0, 100);
        for (int f = 0; f < 3; f++) begin
            random_image(0, 256);
            saved_img[f] = pix_copy;
            stream_frame(0);
            check_frame();
        end
        end_test(2, "random frames back to back");

        for (int f = 0; f < 3; f++) begin
            pix_copy = saved_img[f];
            stream_frame(MAX_GAP);
            check_frame();
        end
        end_test(3, "same frames with gaps");

        random_config(0, 8, -32768, 1);
        random_image(0, 256);
        stream_frame(0);
        check_frame();
        // largest weight, bright pixels
        for (int a = 0; a < N_CH * KERN_N; a++) begin
            cfg_write(cfg_addr_t'(a), 16'h007F);
        end
        cfg_write(cfg_addr_t'(N_CH * KERN_N), 16'h0000);
        cfg_write(cfg_addr_t'(N_CH * KERN_N + 1), 16'h0000);
        random_image(200, 56);
        stream_frame(0);
        check_frame();
        end_test(4, "relu clamp and saturation");

        random_config(-8, 16, -200, 400);
        random_image(0, 256);
        stream_frame(0);
        check_frame();
        // channel 1 only, then an address outside the map
        for (int a = KERN_N; a < 2 * KERN_N; a++) begin
            cfg_write(cfg_addr_t'(a), 16'(rand_range(-128, 256)));
        end
        cfg_write(cfg_addr_t'(N_CH * KERN_N + 1), 16'(rand_range(-500, 1000)));
        cfg_write(cfg_addr_t'(rand_range(CFG_N_REGS, 32 - CFG_N_REGS)), 16'($random(seed)));
        random_image(0, 256);
        stream_frame(0);
        check_frame();
        end_test(5, "configuration rewrite");

        check_value("done_count", frames_sent, done_count);
        end_test(6, "o_done count and timing");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // every strobe, gap and write at most twice over, plus slack
    initial begin
        #(RUN_CYCLES * 2 * CLK_PERIOD + 200 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- src.f
+incdir+tb
logic/cnn_pkg.sv
logic/cnn_weight_regs.sv
logic/conv_window.sv
logic/conv_mac.sv
logic/max_pool.sv
logic/class_scorer.sv
logic/cnn_top.sv
tb/tb_cnn_top.sv

//--- Bender.yml
package:
  name: cnn_classifier

sources:
  - files:
      - logic/cnn_pkg.sv
      - logic/cnn_weight_regs.sv
      - logic/conv_window.sv
      - logic/conv_mac.sv
      - logic/max_pool.sv
      - logic/class_scorer.sv
      - logic/cnn_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_cnn_top.sv
